// File: all.f
+incdir+rtl
rtl/qpu_exu_pkg.sv
rtl/qpu_exu_disp.sv
rtl/qpu_exu_regfile.sv
rtl/qpu_exu_exec.sv
rtl/qpu_exu_queue.sv
rtl/qpu_exu.sv
tests/qpu_exu_tb.sv

// File: tests/qpu_exu_tb.sv
// Execution stage testbench
// Random programs against a model of the registers, the time point and event order

`include "qpu_exu_cfg.svh"

module qpu_exu_tb;

  localparam int N_RANDOM  = 300;
  localparam int N_BURST   = 14;
  localparam int LONG_WAIT = 300;
  localparam int MAX_WAIT  = 63;
  // Eight cycles per instruction at most, plus every wait at its largest
  localparam int WATCHDOG  = 8 * (40 + N_RANDOM + 2 * N_BURST) + N_RANDOM * MAX_WAIT
                             + 2 * LONG_WAIT + 100;

  logic                             i_clk;
  logic                             i_rst;
  logic                             i_instr_valid;
  qpu_exu_pkg::qpu_instr_u          i_instr;
  logic [`QPU_TIME_WIDTH-1:0]       i_timer;
  logic                             o_instr_credit;
  logic [`QPU_EVENT_NUM-1:0]        o_event_valid;
  logic [`QPU_EVENT_WIRE_WIDTH-1:0] o_event_data;
  logic                             o_active;

  // Reference model
  logic [`QPU_XLEN-1:0]             m_regs [16];
  logic [`QPU_TIME_WIDTH-1:0]       m_time;
  logic [`QPU_EVENT_IDX_WIDTH-1:0]  exp_ch [$];
  logic [`QPU_EVENT_WIRE_WIDTH-1:0] exp_data [$];
  logic [`QPU_TIME_WIDTH-1:0]       exp_time [$];

  qpu_exu_pkg::qpu_instr_u          prog [$];    // Words still to send
  int                               credits;
  int                               sent;
  int                               returned;
  logic                             running;
  logic                             stalled;
  logic                             rst_seen;
  string                            test_name;

  qpu_exu dut (
    .i_clk          (i_clk         ),
    .i_rst          (i_rst         ),
    .i_instr_valid  (i_instr_valid ),
    .i_instr        (i_instr       ),
    .i_timer        (i_timer       ),
    .o_instr_credit (o_instr_credit),
    .o_event_valid  (o_event_valid ),
    .o_event_data   (o_event_data  ),
    .o_active       (o_active      )
  );

  initial begin
    i_clk = 1'b0;
    forever #2 i_clk = ~i_clk;
  end

  // Free-running timer, zero in the first cycle after reset
  always @(posedge i_clk) begin
    rst_seen = i_rst;
    #1;
    i_timer = rst_seen ? '0 : i_timer + 1'b1;
  end

  initial begin
    repeat (WATCHDOG) @(posedge i_clk);
    stop_on_error("run did not finish before the watchdog limit");
  end

  ////////////////////////////////////////
  // Checks

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic compare_event(input string name,
                               input logic [`QPU_EVENT_NUM-1:0] exp_valid,
                               input logic [`QPU_EVENT_WIRE_WIDTH-1:0] exp_dat,
                               input logic [`QPU_EVENT_NUM-1:0] act_valid,
                               input logic [`QPU_EVENT_WIRE_WIDTH-1:0] act_dat);
    if (exp_valid !== act_valid || exp_dat !== act_dat) begin
      stop_on_error($sformatf("mismatch %s: expected valid %b data %h, actual valid %b data %h",
                              name, exp_valid, exp_dat, act_valid, act_dat));
    end
  endtask

  task automatic compare_count(input string name, input int exp_cnt, input int act_cnt);
    if (exp_cnt != act_cnt) begin
      stop_on_error($sformatf("mismatch %s: expected %0d, actual %0d", name, exp_cnt, act_cnt));
    end
  endtask

  task automatic compare_flag(input string name, input logic exp_bit, input logic act_bit);
    if (exp_bit !== act_bit) begin
      stop_on_error($sformatf("mismatch %s: expected %b, actual %b", name, exp_bit, act_bit));
    end
  endtask

  // Head of the model queue against the released event
  task automatic check_release();
    logic [`QPU_EVENT_NUM-1:0]       exp_valid;
    logic [`QPU_EVENT_IDX_WIDTH-1:0] ch;
    logic [`QPU_TIME_WIDTH-1:0]      due;
    if (exp_ch.size() == 0) begin
      stop_on_error("event released with nothing scheduled");
    end else begin
      ch = exp_ch.pop_front();
      due = exp_time.pop_front();
      exp_valid = '0;
      exp_valid[ch] = 1'b1;
      compare_event(test_name, exp_valid, exp_data.pop_front(), o_event_valid, o_event_data);
      if (i_timer < due) begin
        stop_on_error($sformatf("event released early at timer %0d, due at %0d", i_timer, due));
      end
    end
  endtask

  // Outputs sampled mid-cycle
  always @(negedge i_clk) begin
    if (running) begin
      if (o_instr_credit) begin
        credits++;
        returned++;
        if (credits > `QPU_CREDITS) begin
          stop_on_error("credit returned with no instruction outstanding");
        end
      end
      if (o_event_valid != '0) begin
        check_release();
      end
    end
  end

  ////////////////////////////////////////
  // Program building and the model

  function automatic qpu_exu_pkg::qpu_instr_u arith_word(input logic [3:0] op,
      input logic [3:0] rd, input logic [3:0] rs1, input logic [3:0] rs2,
      input logic [15:0] imm);
    return {op, rd, rs1, rs2, imm};
  endfunction

  function automatic qpu_exu_pkg::qpu_instr_u wait_word(input logic [23:0] iv);
    return {`QPU_OP_WAIT, 4'h0, iv};
  endfunction

  function automatic qpu_exu_pkg::qpu_instr_u event_word(input logic [1:0] ch,
      input logic [3:0] rs1);
    return {`QPU_OP_EVENT, ch, 2'b00, rs1, 20'h0};
  endfunction

  task automatic apply_model(input qpu_exu_pkg::qpu_instr_u w);
    case (w.arith.opcode)
      `QPU_OP_ADDI: m_regs[w.arith.rd] = m_regs[w.arith.rs1] + 32'(w.arith.imm);
      `QPU_OP_ADD:  m_regs[w.arith.rd] = m_regs[w.arith.rs1] + m_regs[w.arith.rs2];
      `QPU_OP_WAIT: m_time = m_time + w.timing.interval;
      `QPU_OP_EVENT: begin
        exp_ch.push_back(w.evt.channel);
        exp_data.push_back(m_regs[w.evt.rs1][`QPU_EVENT_WIRE_WIDTH-1:0]);
        exp_time.push_back(m_time);   // Scheduled at the current point
      end
      default: ;                      // Unknown opcodes retire with no effect
    endcase
  endtask

  task automatic gen_random(input int n);
    int         sel;
    logic [3:0] op;
    logic [23:0] iv;
    repeat (n) begin
      sel = $urandom_range(0, 99);
      op  = (sel < 30) ? `QPU_OP_ADDI : (sel < 55) ? `QPU_OP_ADD : 4'($urandom_range(5, 15));
      iv  = ($urandom_range(0, 4) == 0) ? 24'($urandom_range(0, MAX_WAIT))
                                         : 24'($urandom_range(0, 7));   // Mostly short
      if (sel >= 55 && sel < 70) begin
        prog.push_back(wait_word(iv));
      end else if (sel >= 70 && sel < 95) begin
        prog.push_back(event_word(2'($urandom), 4'($urandom)));
      end else begin
        prog.push_back(arith_word(op, 4'($urandom), 4'($urandom), 4'($urandom), 16'($urandom)));
      end
    end
  endtask

  task automatic send_prog();
    while (prog.size() != 0) begin
      @(posedge i_clk);
      #1;
      i_instr_valid = 1'b0;
      if (credits == 0) begin
        stalled = 1'b1;
      end else if ($urandom_range(0, 3) != 0) begin   // Idle gap one time in four
        i_instr = prog.pop_front();
        i_instr_valid = 1'b1;
        credits--;
        sent++;
        apply_model(i_instr);
      end
    end
    @(posedge i_clk);
    #1;
    i_instr_valid = 1'b0;
  endtask

  // Waits for the DUT to go idle, then checks nothing was lost
  task automatic drain_and_check();
    while (o_active) begin
      @(negedge i_clk);
    end
    compare_count({test_name, " pending events"}, 0, exp_ch.size());
    compare_count({test_name, " credits"}, sent, returned);
  endtask

  ////////////////////////////////////////
  // Test sequence

  initial begin
    logic [`QPU_TIME_WIDTH-1:0] lag;
    void'($urandom(37390));
    i_rst = 1'b1;
    i_instr_valid = 1'b0;
    i_instr = '0;
    i_timer = '0;
    running = 1'b0;
    stalled = 1'b0;
    credits = `QPU_CREDITS;
    sent = 0;
    returned = 0;
    m_time = '0;
    foreach (m_regs[i]) begin
      m_regs[i] = '0;
    end
    repeat (8) @(posedge i_clk);
    #1;
    i_rst = 1'b0;
    running = 1'b1;

    test_name = "idle";
    repeat (10) begin
      @(negedge i_clk);
      compare_flag("idle event", 1'b0, |o_event_valid);
      compare_flag("idle credit", 1'b0, o_instr_credit);
      compare_flag("idle active", 1'b0, o_active);
    end

    // r1 doubled up to 0xffff0000, then sums past 2^32
    test_name = "arith_wrap";
    prog.push_back(arith_word(`QPU_OP_ADDI, 4'd1, 4'd0, 4'd0, 16'hffff));
    repeat (16) begin
      prog.push_back(arith_word(`QPU_OP_ADD, 4'd1, 4'd1, 4'd1, 16'h0));
    end
    prog.push_back(arith_word(`QPU_OP_ADDI, 4'd4, 4'd1, 4'd0, 16'hffff));   // All ones
    prog.push_back(arith_word(`QPU_OP_ADDI, 4'd5, 4'd4, 4'd0, 16'h0003));
    prog.push_back(arith_word(`QPU_OP_ADD, 4'd6, 4'd4, 4'd4, 16'h0));
    prog.push_back(event_word(2'd1, 4'd5));
    prog.push_back(event_word(2'd2, 4'd6));
    prog.push_back(wait_word(24'd3));
    prog.push_back(event_word(2'd3, 4'd1));
    send_prog();
    drain_and_check();

    test_name = "random";
    gen_random(N_RANDOM);
    send_prog();
    drain_and_check();

    // Long wait ahead of the timer, then more EVENTs than the queue holds
    test_name = "backpressure";
    lag = i_timer - m_time;
    prog.push_back(wait_word(lag[`QPU_TIME_WIDTH-1] ? 24'(LONG_WAIT) : lag + 24'(LONG_WAIT)));
    for (int i = 0; i < N_BURST; i++) begin
      prog.push_back(event_word(2'(i), 4'($urandom)));
      if (i % 5 == 2) begin
        prog.push_back(arith_word(4'($urandom_range(5, 15)), 4'd0, 4'd0, 4'd0, 16'hbeef));
      end
    end
    prog.push_back(event_word(2'd0, 4'd0));   // r0 untouched by the unknown words
    stalled = 1'b0;
    send_prog();
    drain_and_check();
    compare_flag("backpressure stall", 1'b1, stalled);

    $display("Testbench passed");
    $finish;
  end

endmodule

// File: rtl/qpu_exu.sv
// Execution stage top level
// Connects dispatch, register file, execute unit and timing queue

`include "qpu_exu_cfg.svh"

module qpu_exu (
  input  logic                             i_clk,
  input  logic                             i_rst,
  input  logic                             i_instr_valid,
  input  qpu_exu_pkg::qpu_instr_u          i_instr,
  input  logic [`QPU_TIME_WIDTH-1:0]       i_timer,
  output logic                             o_instr_credit,
  output logic [`QPU_EVENT_NUM-1:0]        o_event_valid,
  output logic [`QPU_EVENT_WIRE_WIDTH-1:0] o_event_data,
  output logic                             o_active
);

  // Dispatch to execute
  logic                    issue_valid;
  qpu_exu_pkg::qpu_instr_u issue_instr;
  logic                    disp_busy;

  // Register file ports
  logic [`QPU_RFIDX_WIDTH-1:0] rs1_idx;
  logic [`QPU_RFIDX_WIDTH-1:0] rs2_idx;
  logic [`QPU_XLEN-1:0]        rs1_data;
  logic [`QPU_XLEN-1:0]        rs2_data;
  logic                        rf_wen;
  logic [`QPU_RFIDX_WIDTH-1:0] rf_wr_idx;
  logic [`QPU_XLEN-1:0]        rf_wr_data;
  logic                        time_wen;
  logic [`QPU_TIME_WIDTH-1:0]  time_data;
  logic [`QPU_TIME_WIDTH-1:0]  time_point;

  // Timing queue
  logic                             tiq_push;
  logic [`QPU_TIME_WIDTH-1:0]       tiq_time;
  logic [`QPU_EVENT_IDX_WIDTH-1:0]  tiq_channel;
  logic [`QPU_EVENT_WIRE_WIDTH-1:0] tiq_data;
  logic                             tiq_full;
  logic                             tiq_busy;

  ////////////////////////////////////////
  qpu_exu_disp u_qpu_exu_disp (
    .i_clk          (i_clk         ),
    .i_rst          (i_rst         ),
    .i_instr_valid  (i_instr_valid ),
    .i_instr        (i_instr       ),
    .i_tiq_full     (tiq_full      ),
    .o_issue_valid  (issue_valid   ),
    .o_issue_instr  (issue_instr   ),
    .o_instr_credit (o_instr_credit),
    .o_busy         (disp_busy     )
  );

  qpu_exu_regfile u_qpu_exu_regfile (
    .i_clk        (i_clk     ),
    .i_rst        (i_rst     ),
    .i_rs1_idx    (rs1_idx   ),
    .i_rs2_idx    (rs2_idx   ),
    .i_wen        (rf_wen    ),
    .i_wr_idx     (rf_wr_idx ),
    .i_wr_data    (rf_wr_data),
    .i_time_wen   (time_wen  ),
    .i_time_data  (time_data ),
    .o_rs1_data   (rs1_data  ),
    .o_rs2_data   (rs2_data  ),
    .o_time_point (time_point)
  );

  qpu_exu_exec u_qpu_exu_exec (
    .i_issue_valid (issue_valid),
    .i_issue_instr (issue_instr),
    .i_rs1_data    (rs1_data   ),
    .i_rs2_data    (rs2_data   ),
    .i_time_point  (time_point ),
    .o_rs1_idx     (rs1_idx    ),
    .o_rs2_idx     (rs2_idx    ),
    .o_wen         (rf_wen     ),
    .o_wr_idx      (rf_wr_idx  ),
    .o_wr_data     (rf_wr_data ),
    .o_time_wen    (time_wen   ),
    .o_time_data   (time_data  ),
    .o_tiq_push    (tiq_push   ),
    .o_tiq_time    (tiq_time   ),
    .o_tiq_channel (tiq_channel),
    .o_tiq_data    (tiq_data   )
  );

  qpu_exu_queue u_qpu_exu_queue (
    .i_clk         (i_clk        ),
    .i_rst         (i_rst        ),
    .i_push        (tiq_push     ),
    .i_time        (tiq_time     ),
    .i_channel     (tiq_channel  ),
    .i_data        (tiq_data     ),
    .i_timer       (i_timer      ),
    .o_full        (tiq_full     ),
    .o_event_valid (o_event_valid),
    .o_event_data  (o_event_data ),
    .o_busy        (tiq_busy     )
  );

  assign o_active = disp_busy | tiq_busy;   // Work still buffered or scheduled

endmodule

// File: rtl/qpu_exu_queue.sv
// Timing queue
// Holds scheduled events in push order and releases the head onto
// its one-hot channel once the external timer reaches its time

`include "qpu_exu_cfg.svh"

module qpu_exu_queue (
  input  logic                             i_clk,
  input  logic                             i_rst,
  input  logic                             i_push,
  input  logic [`QPU_TIME_WIDTH-1:0]       i_time,
  input  logic [`QPU_EVENT_IDX_WIDTH-1:0]  i_channel,
  input  logic [`QPU_EVENT_WIRE_WIDTH-1:0] i_data,
  input  logic [`QPU_TIME_WIDTH-1:0]       i_timer,
  output logic                             o_full,
  output logic [`QPU_EVENT_NUM-1:0]        o_event_valid,
  output logic [`QPU_EVENT_WIRE_WIDTH-1:0] o_event_data,
  output logic                             o_busy
);

  localparam int DEPTH = `QPU_TIQ_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Entry storage
  logic [`QPU_TIME_WIDTH-1:0]       time_mem [DEPTH];
  logic [`QPU_EVENT_IDX_WIDTH-1:0]  chan_mem [DEPTH];
  logic [`QPU_EVENT_WIRE_WIDTH-1:0] data_mem [DEPTH];

  logic [PTR_W-1:0]           wr_ptr;
  logic [PTR_W-1:0]           rd_ptr;
  logic [PTR_W:0]             count;
  logic [`QPU_TIME_WIDTH-1:0] head_delta;
  logic                       head_due;
  logic                       pop;

  ////////////////////////////////////////
  // Release of the head

  // Difference keeps the compare correct across timer wrap
  assign head_delta = i_timer - time_mem[rd_ptr];
  assign head_due   = !head_delta[`QPU_TIME_WIDTH-1];
  assign pop        = (count != '0) && head_due;

  always_comb begin
    o_event_valid = '0;
    if (pop) begin
      o_event_valid[chan_mem[rd_ptr]] = 1'b1;
    end
  end

  assign o_event_data = pop ? data_mem[rd_ptr] : '0;
  assign o_full       = (count == (PTR_W+1)'(DEPTH));
  assign o_busy       = (count != '0);

  ////////////////////////////////////////
  // Pointers and occupancy
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({i_push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_push) begin
      time_mem[wr_ptr] <= i_time;
      chan_mem[wr_ptr] <= i_channel;
      data_mem[wr_ptr] <= i_data;
    end
  end

  // Dispatch must hold EVENTs back while the queue is full
  a_no_push_full: assert property (@(posedge i_clk) disable iff (i_rst)
    i_push |-> !o_full);

endmodule

// File: rtl/qpu_exu_exec.sv
// Execute unit
// Decodes the issued word, does the register add or time point update,
// and builds the timing queue entry for an EVENT. Purely combinational.

`include "qpu_exu_cfg.svh"

module qpu_exu_exec (
  input  logic                            i_issue_valid,
  input  qpu_exu_pkg::qpu_instr_u         i_issue_instr,
  input  logic [`QPU_XLEN-1:0]            i_rs1_data,
  input  logic [`QPU_XLEN-1:0]            i_rs2_data,
  input  logic [`QPU_TIME_WIDTH-1:0]      i_time_point,
  output logic [`QPU_RFIDX_WIDTH-1:0]     o_rs1_idx,
  output logic [`QPU_RFIDX_WIDTH-1:0]     o_rs2_idx,
  output logic                            o_wen,
  output logic [`QPU_RFIDX_WIDTH-1:0]     o_wr_idx,
  output logic [`QPU_XLEN-1:0]            o_wr_data,
  output logic                            o_time_wen,
  output logic [`QPU_TIME_WIDTH-1:0]      o_time_data,
  output logic                            o_tiq_push,
  output logic [`QPU_TIME_WIDTH-1:0]      o_tiq_time,
  output logic [`QPU_EVENT_IDX_WIDTH-1:0] o_tiq_channel,
  output logic [`QPU_EVENT_WIRE_WIDTH-1:0] o_tiq_data
);

  localparam int IMM_W = $bits(i_issue_instr.arith.imm);

  logic [`QPU_OPCODE_WIDTH-1:0] opcode;
  logic [`QPU_XLEN-1:0]         imm_ext;
  logic [`QPU_XLEN-1:0]         sum_imm;
  logic [`QPU_XLEN-1:0]         sum_reg;
  logic [`QPU_TIME_WIDTH-1:0]   next_time;

  // Every view carries the opcode in the same place
  assign opcode = i_issue_instr.arith.opcode;

  ////////////////////////////////////////
  // Operand reads

  assign o_rs1_idx = i_issue_instr.arith.rs1;     // Also the EVENT data source
  assign o_rs2_idx = i_issue_instr.arith.rs2;

  ////////////////////////////////////////
  // Datapath

  assign imm_ext   = {{(`QPU_XLEN-IMM_W){1'b0}}, i_issue_instr.arith.imm};
  assign sum_imm   = i_rs1_data + imm_ext;         // Wraps modulo 2^32
  assign sum_reg   = i_rs1_data + i_rs2_data;
  assign next_time = i_time_point + i_issue_instr.timing.interval;

  ////////////////////////////////////////
  // Decode and write-back

  always_comb begin
    o_wen         = 1'b0;
    o_wr_idx      = i_issue_instr.arith.rd;
    o_wr_data     = sum_imm;
    o_time_wen    = 1'b0;
    o_time_data   = next_time;
    o_tiq_push    = 1'b0;
    o_tiq_time    = i_time_point;                  // Event fires at the current point
    o_tiq_channel = i_issue_instr.evt.channel;
    o_tiq_data    = i_rs1_data[`QPU_EVENT_WIRE_WIDTH-1:0];

    if (i_issue_valid) begin
      case (opcode)
        `QPU_OP_ADDI: begin
          o_wen     = 1'b1;
          o_wr_data = sum_imm;
        end
        `QPU_OP_ADD: begin
          o_wen     = 1'b1;
          o_wr_data = sum_reg;
        end
        `QPU_OP_WAIT: begin
          o_time_wen = 1'b1;
        end
        `QPU_OP_EVENT: begin
          o_tiq_push = 1'b1;
        end
        default: begin
          // Retired as a no-op
          o_wen = 1'b0;
        end
      endcase
    end
  end

endmodule

// File: rtl/qpu_exu_regfile.sv
// Classical register file
// 16 general registers with combinational reads, plus the time point

`include "qpu_exu_cfg.svh"

module qpu_exu_regfile (
  input  logic                        i_clk,
  input  logic                        i_rst,
  input  logic [`QPU_RFIDX_WIDTH-1:0] i_rs1_idx,
  input  logic [`QPU_RFIDX_WIDTH-1:0] i_rs2_idx,
  input  logic                        i_wen,
  input  logic [`QPU_RFIDX_WIDTH-1:0] i_wr_idx,
  input  logic [`QPU_XLEN-1:0]        i_wr_data,
  input  logic                        i_time_wen,
  input  logic [`QPU_TIME_WIDTH-1:0]  i_time_data,
  output logic [`QPU_XLEN-1:0]        o_rs1_data,
  output logic [`QPU_XLEN-1:0]        o_rs2_data,
  output logic [`QPU_TIME_WIDTH-1:0]  o_time_point
);

  localparam int NREGS = 1 << `QPU_RFIDX_WIDTH;

  logic [`QPU_XLEN-1:0]       regs [NREGS];
  logic [`QPU_TIME_WIDTH-1:0] time_point;

  ////////////////////////////////////////
  // Classical registers

  // Every register is writable, r0 included
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen) begin
      regs[i_wr_idx] <= i_wr_data;
    end
  end

  assign o_rs1_data = regs[i_rs1_idx];
  assign o_rs2_data = regs[i_rs2_idx];

  ////////////////////////////////////////
  // Time point

  // Scheduling reference for EVENT, moved forward only by WAIT
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      time_point <= '0;
    end else if (i_time_wen) begin
      time_point <= i_time_data;
    end
  end

  assign o_time_point = time_point;

endmodule

// File: rtl/qpu_exu_disp.sv
// Dispatch buffer
// Takes instruction words against credits and issues them in order.
// An EVENT waits at the head while the timing queue is full.

`include "qpu_exu_cfg.svh"

module qpu_exu_disp (
  input  logic                    i_clk,
  input  logic                    i_rst,
  input  logic                    i_instr_valid,
  input  qpu_exu_pkg::qpu_instr_u i_instr,
  input  logic                    i_tiq_full,
  output logic                    o_issue_valid,
  output qpu_exu_pkg::qpu_instr_u o_issue_instr,
  output logic                    o_instr_credit,
  output logic                    o_busy
);

  localparam int DEPTH = `QPU_CREDITS;
  localparam int PTR_W = $clog2(DEPTH);

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  qpu_exu_pkg::qpu_instr_u instr_mem [DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             head_is_event;
  logic             issue;

  ////////////////////////////////////////
  // Issue decision
  assign head_is_event = (instr_mem[rd_ptr].evt.opcode == `QPU_OP_EVENT);
  assign issue         = (count != '0) && !(head_is_event && i_tiq_full);

  assign o_issue_valid  = issue;
  assign o_issue_instr  = instr_mem[rd_ptr];
  assign o_instr_credit = issue;          // Slot frees as the head leaves
  assign o_busy         = (count != '0);

  ////////////////////////////////////////
  // Buffer control
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_instr_valid) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (issue) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({i_instr_valid, issue})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Payload
  always_ff @(posedge i_clk) begin
    if (i_instr_valid) begin
      instr_mem[wr_ptr] <= i_instr;
    end
  end

  ////////////////////////////////////////
  // Checks

  // Sender keeps to its credits, a full buffer takes a word only as the head leaves
  a_no_overflow: assert property (@(posedge i_clk) disable iff (i_rst)
    i_instr_valid |-> (count != (PTR_W+1)'(DEPTH)) || issue);

  // A credit only frees a slot that the pointers show as occupied
  a_credit_is_issue: assert property (@(posedge i_clk) disable iff (i_rst)
    o_instr_credit |-> (wr_ptr != rd_ptr) || (count == (PTR_W+1)'(DEPTH)));

endmodule

// File: rtl/qpu_exu_pkg.sv
// Execution stage types
// The instruction word with its arithmetic, timing and event views

`include "qpu_exu_cfg.svh"

package qpu_exu_pkg;

  // ADDI and ADD
  typedef struct packed {
    logic [`QPU_OPCODE_WIDTH-1:0] opcode;
    logic [`QPU_RFIDX_WIDTH-1:0]  rd;
    logic [`QPU_RFIDX_WIDTH-1:0]  rs1;
    logic [`QPU_RFIDX_WIDTH-1:0]  rs2;
    logic [`QPU_INSTR_SIZE-`QPU_OPCODE_WIDTH-3*`QPU_RFIDX_WIDTH-1:0] imm; // Zero-extended
  } qpu_arith_t;

  // WAIT
  typedef struct packed {
    logic [`QPU_OPCODE_WIDTH-1:0] opcode;
    logic [`QPU_INSTR_SIZE-`QPU_OPCODE_WIDTH-`QPU_TIME_WIDTH-1:0] spare;
    logic [`QPU_TIME_WIDTH-1:0]   interval;
  } qpu_timing_t;

  // EVENT, rs1 sits where the arithmetic view has it
  typedef struct packed {
    logic [`QPU_OPCODE_WIDTH-1:0]    opcode;
    logic [`QPU_EVENT_IDX_WIDTH-1:0] channel;
    logic [`QPU_RFIDX_WIDTH-`QPU_EVENT_IDX_WIDTH-1:0] spare_hi;
    logic [`QPU_RFIDX_WIDTH-1:0]     rs1;
    logic [`QPU_INSTR_SIZE-`QPU_OPCODE_WIDTH-2*`QPU_RFIDX_WIDTH-1:0] spare_lo;
  } qpu_event_t;

  // One word, three decodes
  typedef union packed {
    qpu_arith_t  arith;
    qpu_timing_t timing;
    qpu_event_t  evt;
  } qpu_instr_u;

endpackage

// File: rtl/qpu_exu_cfg.svh
// Execution stage configuration
// Widths, depths, credit count and opcode values shared by all blocks

`ifndef QPU_EXU_CFG_SVH
`define QPU_EXU_CFG_SVH

`define QPU_INSTR_SIZE        32
`define QPU_XLEN              32
`define QPU_RFIDX_WIDTH       4     // 16 classical registers
`define QPU_TIME_WIDTH        24
`define QPU_EVENT_NUM         4
`define QPU_EVENT_IDX_WIDTH   2     // Selects one of QPU_EVENT_NUM channels
`define QPU_EVENT_WIRE_WIDTH  16
`define QPU_TIQ_DEPTH         8
`define QPU_CREDITS           4     // Also the dispatch buffer depth

// Opcodes live in the top bits of every instruction word
`define QPU_OPCODE_WIDTH      4
`define QPU_OP_ADDI           4'd1
`define QPU_OP_ADD            4'd2
`define QPU_OP_WAIT           4'd3
`define QPU_OP_EVENT          4'd4

`endif
